// ==== logic/irPkg.sv ====
package irPkg;

  // Datapath widths
  localparam int adWidth       = 36;
  localparam int irWidth       = 13;
  localparam int opWidth       = 9;
  localparam int acWidth       = 4;
  localparam int modeWidth     = 2;
  localparam int magicWidth    = 2;
  localparam int normWidth     = 3;
  localparam int diagWidth     = 6;

  // Dispatch word fields, MSB first: A, B, parity, J
  localparam int aWidth        = 3;
  localparam int bWidth        = 3;
  localparam int jWidth        = 8;
  localparam int aPos          = 0;
  localparam int bPos          = aPos + aWidth;
  localparam int parityPos     = bPos + bWidth;
  localparam int jPos          = parityPos + 1;
  localparam int dramWidth     = jPos + jWidth;

  localparam int dramAddrWidth = 9;
  localparam int dramDepth     = 1 << dramAddrWidth;

  // JRST is opcode 254 octal
  localparam logic [0:opWidth-1] jrstOpcode = 9'o254;

  // Diagnostic readout selects, one per 6-bit word
  typedef enum logic [2:0] {
    diagNormAddrHi = 3'd0,
    diagAddrLo     = 3'd1,
    diagModeAc     = 3'd2,
    diagAB         = 3'd3,
    diagTestJ      = 3'd4,
    diagParity     = 3'd5,
    diagStatus     = 3'd6,
    diagIr         = 3'd7
  } diagSelE;

  // Role of each B field bit in the skip/jump test
  typedef enum logic [1:0] {
    condInvert    = 2'd0,
    condEqual     = 2'd1,
    condMagnitude = 2'd2
  } testCondE;

endpackage

// ==== logic/dispatchIf.sv ====
`timescale 1ns/10ps

// Latched instruction and dispatch fields
interface dispatchIf
  import irPkg::*;
();

  logic [0:irWidth-1]       ir;
  logic [0:acWidth-1]       irAc;
  logic [0:dramAddrWidth-1] dramAddr;
  logic [0:aWidth-1]        dramA;
  logic [0:bWidth-1]        dramB;
  logic                     dramParity;
  logic [0:jWidth-1]        dramJ;
  logic                     jrst0;
  logic                     ioEnable;
  logic                     acEnable;

  modport source(output ir, irAc, dramAddr, dramA, dramB, dramParity, dramJ, jrst0,
                        ioEnable, acEnable);
  modport sink(input ir, irAc, dramAddr, dramA, dramB, dramParity, dramJ, jrst0,
                     ioEnable, acEnable);

endinterface

// ==== logic/adStatusIf.sv ====
`timescale 1ns/10ps

// Adder word status
interface adStatusIf
  import irPkg::*;
();

  logic                 adZero;
  logic                 adSign;
  logic                 adCarry;
  logic [0:normWidth-1] normCode;

  modport source(output adZero, adSign, adCarry, normCode);
  modport sink(input adZero, adSign, adCarry, normCode);

endinterface

// ==== logic/dispatchRam.sv ====
`timescale 1ns/10ps

module dispatchRam
  import irPkg::*;
(
  input  logic                     CON,
  input  logic                     writeEnable,
  input  logic [0:dramAddrWidth-1] writeAddr,
  input  logic [0:dramWidth-1]     writeData,
  input  logic [0:dramAddrWidth-1] readAddr,
  output logic [0:dramWidth-1]     readData
);

  logic [0:dramWidth-1] mem [dramDepth];

  // Loaded by the write port only
  always_ff @(posedge CON) begin
    if (writeEnable) begin
      mem[writeAddr] <= writeData;
    end
  end

  // Registered read, one cycle
  always_ff @(posedge CON) begin
    readData <= mem[readAddr];
  end

endmodule

// ==== logic/instrLatch.sv ====
`timescale 1ns/10ps

module instrLatch
  import irPkg::*;
(
  input  logic                     CON,
  input  logic                     reset,
  input  logic                     loadIr,
  input  logic                     mbXfer,
  input  logic [0:adWidth-1]       adData,
  input  logic [0:adWidth-1]       cacheData,
  input  logic                     modeWrite,
  input  logic [modeWidth-1:0]     modeData,
  input  logic                     loadDram,
  output logic [0:dramAddrWidth-1] ramReadAddr,
  input  logic [0:dramWidth-1]     ramReadData,
  output logic                     dramValid,
  dispatchIf.source                dispatch
);

  logic [0:irWidth-1]       ir;
  logic [0:acWidth-1]       irAc;
  logic                     ioEnable;
  logic                     acEnable;
  logic [0:dramAddrWidth-1] dramAddr;
  logic [0:dramAddrWidth-1] nextAddr;
  logic                     isJrst;
  logic                     isIo;
  logic                     ioAllOnes;
  logic [0:jWidth-1]        wordJ;
  logic [0:aWidth-1]        dramA;
  logic [0:bWidth-1]        dramB;
  logic                     dramParity;
  logic [0:jWidth-1]        dramJ;
  // Stage 1 is address latched, stage 2 is RAM data ready
  logic                     addrValid;
  logic                     readValid;
  logic                     jrstAddr;
  logic                     jrstRead;
  logic [0:acWidth-1]       acAddr;
  logic [0:acWidth-1]       acRead;

  assign isJrst    = ir[0:opWidth-1] == jrstOpcode;
  assign isIo      = (&ir[0:2]) & ioEnable;
  assign ioAllOnes = &ir[3:6];

  // 7xx I/O instructions dispatch on device bits instead of opcode bits 3-8
  always_comb begin
    nextAddr[0:2] = ir[0:2];
    if (isIo) begin
      nextAddr[3:5] = ir[7:9] | {3{ioAllOnes}};
      nextAddr[6:8] = ir[10:12];
    end else begin
      nextAddr[3:8] = ir[3:8];
    end
  end

  always_ff @(posedge CON) begin
    if (reset) begin
      ir       <= '0;
      irAc     <= '0;
      ioEnable <= 1'b0;
      acEnable <= 1'b0;
    end else begin
      if (loadIr) begin
        ir   <= mbXfer ? adData[0:irWidth-1] : cacheData[0:irWidth-1];
        irAc <= acEnable ? ir[opWidth +: acWidth] : '0;
      end
      if (modeWrite) begin
        ioEnable <= modeData[1];
        acEnable <= modeData[0];
      end
    end
  end

  // JRST puts its AC field in the low J nibble
  assign wordJ = jrstRead ? {ramReadData[jPos +: jWidth-acWidth], acRead}
                          : ramReadData[jPos +: jWidth];

  always_ff @(posedge CON) begin
    if (reset) begin
      addrValid  <= 1'b0;
      readValid  <= 1'b0;
      dramValid  <= 1'b0;
      jrstAddr   <= 1'b0;
      jrstRead   <= 1'b0;
      acAddr     <= '0;
      acRead     <= '0;
      dramAddr   <= '0;
      dramA      <= '0;
      dramB      <= '0;
      dramParity <= 1'b0;
      dramJ      <= '0;
    end else begin
      addrValid <= loadDram;
      readValid <= addrValid;
      dramValid <= readValid;
      jrstRead  <= jrstAddr;
      acRead    <= acAddr;
      if (loadDram) begin
        dramAddr <= nextAddr;
        jrstAddr <= isJrst;
        acAddr   <= ir[opWidth +: acWidth];
      end
      if (readValid) begin
        dramA      <= ramReadData[aPos +: aWidth];
        dramB      <= ramReadData[bPos +: bWidth];
        dramParity <= ramReadData[parityPos];
        dramJ      <= wordJ;
      end
    end
  end

  assign ramReadAddr = dramAddr;

  assign dispatch.ir         = ir;
  assign dispatch.irAc       = irAc;
  assign dispatch.dramAddr   = dramAddr;
  assign dispatch.dramA      = dramA;
  assign dispatch.dramB      = dramB;
  assign dispatch.dramParity = dramParity;
  assign dispatch.dramJ      = dramJ;
  assign dispatch.jrst0      = isJrst & (ir[opWidth +: acWidth] == '0);
  assign dispatch.ioEnable   = ioEnable;
  assign dispatch.acEnable   = acEnable;

endmodule

// ==== logic/adCondition.sv ====
`timescale 1ns/10ps

module adCondition
  import irPkg::*;
(
  input  logic               CON,
  input  logic               reset,
  input  logic               adStrobe,
  input  logic [0:adWidth-1] adData,
  input  logic               adCarryIn,
  output logic               adValid,
  adStatusIf.source          status
);

  logic [0:adWidth-1]   adWord;
  logic                 adCarry;
  logic [0:normWidth-1] normCode;

  always_ff @(posedge CON) begin
    if (reset) begin
      adWord  <= '0;
      adCarry <= 1'b0;
      adValid <= 1'b0;
    end else begin
      adValid <= adStrobe;
      if (adStrobe) begin
        adWord  <= adData;
        adCarry <= adCarryIn;
      end
    end
  end

  // Normalize priority encoder, bit 0 is the sign
  always_comb begin
    if (adWord[0]) begin
      normCode = normWidth'(1);
    end else if (|adWord[1:6]) begin
      normCode = normWidth'(2);
    end else if (adWord[7]) begin
      normCode = normWidth'(3);
    end else if (adWord[8]) begin
      normCode = normWidth'(4);
    end else if (adWord[9]) begin
      normCode = normWidth'(5);
    end else if (adWord[10]) begin
      normCode = normWidth'(6);
    end else if (|adWord[11:adWidth-1]) begin
      normCode = normWidth'(7);
    end else begin
      normCode = '0;
    end
  end

  assign status.adZero   = ~|adWord;
  assign status.adSign   = adWord[0];
  assign status.adCarry  = adCarry;
  assign status.normCode = normCode;

endmodule

// ==== logic/diagSelect.sv ====
`timescale 1ns/10ps

module diagSelect
  import irPkg::*;
(
  input  logic                  CON,
  input  logic                  reset,
  dispatchIf.sink               dispatch,
  adStatusIf.sink               status,
  input  logic [magicWidth-1:0] magic,
  input  logic                  diagRead,
  input  diagSelE               diagFunc,
  output logic                  testSatisfied,
  output logic                  parityOk,
  output logic                  diagDriving,
  output logic [0:diagWidth-1]  diagData
);

  logic                 testNow;
  logic                 parityNow;
  logic                 ioLegal;
  logic                 acZero;
  logic [0:diagWidth-1] diagWord;

  // EQ, GT, LT and carry terms, sense flipped by the invert bit
  assign testNow = |{dispatch.dramB[condEqual] & status.adZero,
                     dispatch.dramB[condMagnitude] & magic[1] & ~status.adSign & ~status.adZero,
                     dispatch.dramB[condMagnitude] & magic[0] & status.adSign,
                     (magic[1] ^ magic[0]) & status.adCarry}
                   ^ dispatch.dramB[condInvert];

  // Odd parity over the whole dispatch word
  assign parityNow = ^{dispatch.dramA, dispatch.dramB, dispatch.dramParity, dispatch.dramJ};

  assign ioLegal = &dispatch.ir[3:6];
  assign acZero  = dispatch.ir[opWidth +: acWidth] == '0;

  always_comb begin
    diagWord = '0;
    case (diagFunc)
      diagNormAddrHi: diagWord = {status.normCode, dispatch.dramAddr[0:2]};
      diagAddrLo:     diagWord = dispatch.dramAddr[3:8];
      diagModeAc:     diagWord = {dispatch.ioEnable, dispatch.acEnable, dispatch.irAc};
      diagAB:         diagWord = {dispatch.dramA, dispatch.dramB};
      diagTestJ:      diagWord = {testNow, dispatch.jrst0, dispatch.dramJ[1:4]};
      diagParity:     diagWord = {dispatch.dramParity, parityNow,
                                  dispatch.dramJ[jWidth-acWidth +: acWidth]};
      diagStatus:     diagWord = {status.adZero, ioLegal, status.adSign, status.adCarry,
                                  acZero, 1'b0};
      diagIr:         diagWord = dispatch.ir[0:diagWidth-1];
      default:        diagWord = '0;
    endcase
  end

  always_ff @(posedge CON) begin
    if (reset) begin
      testSatisfied <= 1'b0;
      parityOk      <= 1'b0;
      diagDriving   <= 1'b0;
      diagData      <= '0;
    end else begin
      testSatisfied <= testNow;
      parityOk      <= parityNow;
      diagDriving   <= diagRead;
      // Bus is quiet unless a read was requested
      diagData      <= diagRead ? diagWord : '0;
    end
  end

endmodule

// ==== logic/irBoard.sv ====
`timescale 1ns/10ps

module irBoard
  import irPkg::*;
(
  input  logic                     CON,
  input  logic                     reset,
  input  logic                     loadIr,
  input  logic                     mbXfer,
  input  logic [0:adWidth-1]       adData,
  input  logic [0:adWidth-1]       cacheData,
  input  logic                     modeWrite,
  input  logic [modeWidth-1:0]     modeData,
  input  logic                     loadDram,
  input  logic                     ramWrite,
  input  logic [0:dramAddrWidth-1] ramAddr,
  input  logic [0:dramWidth-1]     ramData,
  input  logic                     adStrobe,
  input  logic                     adCarryIn,
  input  logic [magicWidth-1:0]    magic,
  input  logic                     diagRead,
  input  diagSelE                  diagFunc,
  output logic                     dramValid,
  output logic                     adValid,
  output logic [0:aWidth-1]        dispatchA,
  output logic [0:bWidth-1]        dispatchB,
  output logic [0:jWidth-1]        dispatchJ,
  output logic [0:acWidth-1]       irAc,
  output logic                     testSatisfied,
  output logic                     parityOk,
  output logic                     diagDriving,
  output logic [0:diagWidth-1]     diagData
);

  logic [0:dramAddrWidth-1] ramReadAddr;
  logic [0:dramWidth-1]     ramReadData;

  dispatchIf dispatchBus ();
  adStatusIf adStatusBus ();

  dispatchRam i_dispatchRam (
    .CON         (CON),
    .writeEnable (ramWrite),
    .writeAddr   (ramAddr),
    .writeData   (ramData),
    .readAddr    (ramReadAddr),
    .readData    (ramReadData)
  );

  instrLatch i_instrLatch (
    .CON         (CON),
    .reset       (reset),
    .loadIr      (loadIr),
    .mbXfer      (mbXfer),
    .adData      (adData),
    .cacheData   (cacheData),
    .modeWrite   (modeWrite),
    .modeData    (modeData),
    .loadDram    (loadDram),
    .ramReadAddr (ramReadAddr),
    .ramReadData (ramReadData),
    .dramValid   (dramValid),
    .dispatch    (dispatchBus.source)
  );

  adCondition i_adCondition (
    .CON       (CON),
    .reset     (reset),
    .adStrobe  (adStrobe),
    .adData    (adData),
    .adCarryIn (adCarryIn),
    .adValid   (adValid),
    .status    (adStatusBus.source)
  );

  diagSelect i_diagSelect (
    .CON           (CON),
    .reset         (reset),
    .dispatch      (dispatchBus.sink),
    .status        (adStatusBus.sink),
    .magic         (magic),
    .diagRead      (diagRead),
    .diagFunc      (diagFunc),
    .testSatisfied (testSatisfied),
    .parityOk      (parityOk),
    .diagDriving   (diagDriving),
    .diagData      (diagData)
  );

  assign dispatchA = dispatchBus.dramA;
  assign dispatchB = dispatchBus.dramB;
  assign dispatchJ = dispatchBus.dramJ;
  assign irAc      = dispatchBus.irAc;

endmodule

// ==== tests/clockGen.sv ====
`timescale 1ns/10ps

module clockGen (
  output logic CON,
  output logic reset
);

  initial begin
    CON = 1'b0;
    forever #4 CON = ~CON;
  end

  // Reset for four rising edges, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge CON);
    @(negedge CON);
    reset <= 1'b0;
  end

endmodule

// ==== tests/irBoardTb.sv ====
`timescale 1ns/10ps

module irBoardTb
  import irPkg::*;
();

  localparam int maxRecords    = 64;
  localparam int timeoutCycles = 20;

  logic                     CON;
  logic                     reset;
  logic                     loadIr;
  logic                     mbXfer;
  logic [0:adWidth-1]       adData;
  logic [0:adWidth-1]       cacheData;
  logic                     modeWrite;
  logic [modeWidth-1:0]     modeData;
  logic                     loadDram;
  logic                     ramWrite;
  logic [0:dramAddrWidth-1] ramAddr;
  logic [0:dramWidth-1]     ramData;
  logic                     adStrobe;
  logic                     adCarryIn;
  logic [magicWidth-1:0]    magic;
  logic                     diagRead;
  diagSelE                  diagFunc;
  logic                     dramValid;
  logic                     adValid;
  logic [0:aWidth-1]        dispatchA;
  logic [0:bWidth-1]        dispatchB;
  logic [0:jWidth-1]        dispatchJ;
  logic [0:acWidth-1]       irAc;
  logic                     testSatisfied;
  logic                     parityOk;
  logic                     diagDriving;
  logic [0:diagWidth-1]     diagData;

  // Reference model state
  logic [0:dramWidth-1]     ramModel [dramDepth];
  logic [0:irWidth-1]       irModel;
  logic [0:acWidth-1]       irAcModel;
  logic                     ioEnModel;
  logic                     acEnModel;
  logic [0:aWidth-1]        aModel;
  logic [0:bWidth-1]        bModel;
  logic                     pModel;
  logic [0:jWidth-1]        jModel;
  logic [0:dramAddrWidth-1] addrModel;
  logic [0:adWidth-1]       adModel;
  logic                     carryModel;
  logic [1:0]               magicModel;
  logic [0:2]               normModel;
  logic [63:0]              testData [maxRecords*4];
  int                       seed;

  clockGen i_clockGen (.CON(CON), .reset(reset));

  irBoard i_dut (
    .CON(CON), .reset(reset), .loadIr(loadIr), .mbXfer(mbXfer), .adData(adData),
    .cacheData(cacheData), .modeWrite(modeWrite), .modeData(modeData),
    .loadDram(loadDram), .ramWrite(ramWrite), .ramAddr(ramAddr), .ramData(ramData),
    .adStrobe(adStrobe), .adCarryIn(adCarryIn), .magic(magic), .diagRead(diagRead),
    .diagFunc(diagFunc), .dramValid(dramValid), .adValid(adValid),
    .dispatchA(dispatchA), .dispatchB(dispatchB), .dispatchJ(dispatchJ), .irAc(irAc),
    .testSatisfied(testSatisfied), .parityOk(parityOk), .diagDriving(diagDriving),
    .diagData(diagData)
  );

  task automatic checkVal(input string name, input logic [63:0] expVal,
                          input logic [63:0] actVal);
    assert (expVal === actVal) else begin
      $display("FAIL %s: expected %0h, actual %0h", name, expVal, actVal);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic timeoutFail(input string what);
    $display("Timed out after %0d cycles waiting for %s", timeoutCycles, what);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  endtask

  // Counts falling edges until the selected valid is high
  task automatic waitValid(input bit useDram, output int cycles);
    cycles = 0;
    while ((useDram ? dramValid : adValid) !== 1'b1) begin
      @(negedge CON);
      cycles++;
      if (cycles > timeoutCycles) begin
        timeoutFail(useDram ? "dramValid" : "adValid");
      end
    end
  endtask

  // EQ, GT, LT and carry terms inverted by B bit 0
  function automatic logic testExpect();
    logic eq;
    logic gt;
    logic lt;
    logic cy;
    eq = bModel[1] & (adModel == '0);
    gt = bModel[2] & magicModel[1] & ~adModel[0] & (adModel != '0);
    lt = bModel[2] & magicModel[0] & adModel[0];
    cy = (magicModel[1] ^ magicModel[0]) & carryModel;
    return (eq | gt | lt | cy) ^ bModel[0];
  endfunction

  function automatic logic parityExpect();
    return ^{aModel, bModel, pModel, jModel};
  endfunction

  function automatic logic [0:5] diagExpect(input diagSelE func);
    logic jrst0;
    jrst0 = (irModel[0:8] == 9'o254) && (irModel[9:12] == 4'd0);
    case (func)
      diagNormAddrHi: return {normModel, addrModel[0:2]};
      diagAddrLo:     return addrModel[3:8];
      diagModeAc:     return {ioEnModel, acEnModel, irAcModel};
      diagAB:         return {aModel, bModel};
      diagTestJ:      return {testExpect(), jrst0, jModel[1:4]};
      diagParity:     return {pModel, parityExpect(), jModel[4:7]};
      diagStatus:     return {adModel == '0, &irModel[3:6], adModel[0], carryModel,
                              irModel[9:12] == 4'd0, 1'b0};
      default:        return irModel[0:5];
    endcase
  endfunction

  // Every task starts and ends on a falling edge
  task automatic fillRam();
    logic [0:dramWidth-1] value;
    for (int a = 0; a < dramDepth; a++) begin
      value       = dramWidth'($random(seed));
      ramWrite    = 1'b1;
      ramAddr     = dramAddrWidth'(a);
      ramData     = value;
      ramModel[a] = value;
      @(negedge CON);
    end
    ramWrite = 1'b0;
  endtask

  task automatic writeRam(input logic [0:dramAddrWidth-1] addr,
                          input logic [0:dramWidth-1] word);
    ramWrite       = 1'b1;
    ramAddr        = addr;
    ramData        = word;
    ramModel[addr] = word;
    @(negedge CON);
    ramWrite = 1'b0;
  endtask

  task automatic writeMode(input logic [1:0] m);
    modeWrite = 1'b1;
    modeData  = m;
    @(negedge CON);
    modeWrite = 1'b0;
    ioEnModel = m[1];
    acEnModel = m[0];
  endtask

  task automatic readDiag(input diagSelE func);
    diagRead = 1'b1;
    diagFunc = func;
    @(negedge CON);
    diagRead = 1'b0;
    checkVal($sformatf("diag %s", func.name()), diagExpect(func), diagData);
    checkVal("diagDriving", 1, diagDriving);
    checkVal("testSatisfied", testExpect(), testSatisfied);
    checkVal("parityOk", parityExpect(), parityOk);
    @(negedge CON);
    checkVal("diagData idle", 0, diagData);
    checkVal("diagDriving idle", 0, diagDriving);
  endtask

  task automatic dispatchInstr(input logic [0:irWidth-1] instr, input bit viaAdder,
                               input bit twice, input logic [0:dramAddrWidth-1] expAddr);
    int                   cycles;
    logic [0:dramWidth-1] word;
    loadIr = 1'b1;
    mbXfer = viaAdder;
    if (viaAdder) begin
      adData = {instr, {(adWidth-irWidth){1'b0}}};
    end else begin
      cacheData = {instr, {(adWidth-irWidth){1'b0}}};
    end
    @(negedge CON);
    loadIr    = 1'b0;
    irAcModel = acEnModel ? irModel[9:12] : 4'd0;
    irModel   = instr;
    checkVal("irAc", irAcModel, irAc);
    loadDram = 1'b1;
    @(negedge CON);
    if (twice) begin
      @(negedge CON);
    end
    loadDram = 1'b0;
    word      = ramModel[expAddr];
    addrModel = expAddr;
    aModel    = word[0:2];
    bModel    = word[3:5];
    pModel    = word[6];
    jModel    = word[7:14];
    // JRST carries its AC in the J low nibble
    if (instr[0:8] == 9'o254) begin
      jModel[4:7] = instr[9:12];
    end
    waitValid(1'b1, cycles);
    checkVal("dramValid latency", twice ? 1 : 2, cycles);
    checkVal("dispatchA", aModel, dispatchA);
    checkVal("dispatchB", bModel, dispatchB);
    checkVal("dispatchJ", jModel, dispatchJ);
    if (twice) begin
      @(negedge CON);
      checkVal("second dramValid", 1, dramValid);
    end
    @(negedge CON);
    checkVal("dramValid pulse end", 0, dramValid);
    readDiag(diagAddrLo);
  endtask

  task automatic adderTest(input logic [0:adWidth-1] word, input logic [2:0] mc,
                           input logic [0:2] expNorm);
    int cycles;
    adData     = word;
    adCarryIn  = mc[0];
    magic      = mc[2:1];
    adStrobe   = 1'b1;
    @(negedge CON);
    adStrobe   = 1'b0;
    adModel    = word;
    carryModel = mc[0];
    magicModel = mc[2:1];
    normModel  = expNorm;
    waitValid(1'b0, cycles);
    checkVal("adValid latency", 0, cycles);
    @(negedge CON);
    checkVal("adValid pulse end", 0, adValid);
    readDiag(diagNormAddrHi);
    readDiag(diagStatus);
  endtask

  initial begin
    int          cycles;
    logic [63:0] kind;
    logic [63:0] arg1;
    logic [63:0] arg2;
    logic [63:0] expVal;
    loadIr = 1'b0;
    mbXfer = 1'b0;
    adData = '0;
    cacheData = '0;
    modeWrite = 1'b0;
    modeData = '0;
    loadDram = 1'b0;
    ramWrite = 1'b0;
    ramAddr = '0;
    ramData = '0;
    adStrobe = 1'b0;
    adCarryIn = 1'b0;
    magic = '0;
    diagRead = 1'b0;
    diagFunc = diagNormAddrHi;
    seed = 32'h536;
    irModel = '0;
    irAcModel = '0;
    ioEnModel = 1'b0;
    acEnModel = 1'b0;
    {aModel, bModel, pModel, jModel} = '0;
    addrModel = '0;
    adModel = '0;
    carryModel = 1'b0;
    magicModel = '0;
    normModel = '0;
    for (int i = 0; i < maxRecords*4; i++) begin
      testData[i] = '0;
    end
    $readmemh("tests/irTestdata.mem", testData);

    cycles = 0;
    @(negedge CON);
    while (reset) begin
      @(negedge CON);
      cycles++;
      if (cycles > timeoutCycles) begin
        timeoutFail("reset release");
      end
    end
    checkVal("dramValid after reset", 0, dramValid);
    checkVal("adValid after reset", 0, adValid);
    checkVal("diagDriving after reset", 0, diagDriving);
    checkVal("diagData after reset", 0, diagData);
    checkVal("dispatch fields after reset", 0, {dispatchA, dispatchB, dispatchJ, irAc});

    fillRam();
    for (int r = 0; r < maxRecords; r++) begin
      kind   = testData[r*4];
      arg1   = testData[r*4+1];
      arg2   = testData[r*4+2];
      expVal = testData[r*4+3];
      if (kind == 0) begin
        break;
      end
      case (kind)
        1:       writeRam(arg1[8:0], arg2[14:0]);
        2:       writeMode(arg1[1:0]);
        3:       dispatchInstr(arg1[12:0], arg2[0], arg2[1], expVal[8:0]);
        4:       adderTest(arg1[35:0], arg2[2:0], expVal[2:0]);
        default: readDiag(diagSelE'(arg1[2:0]));
      endcase
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
logic/irPkg.sv
logic/dispatchIf.sv
logic/adStatusIf.sv
logic/dispatchRam.sv
logic/instrLatch.sv
logic/adCondition.sv
logic/diagSelect.sv
logic/irBoard.sv
tests/clockGen.sv
tests/irBoardTb.sv

// ==== Makefile ====
# Verilator build and run for the IR board testbench

VERILATOR ?= verilator
TOP       ?= irBoardTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/irTestdata.mem ====
// Columns: kind arg1 arg2 expected, hex; kind 1 RAM write (addr word), 2 mode (data)
// 3 dispatch (ir, bit0 mbXfer bit1 twice, addr), 4 adder (word, magic carry, norm), 5 diag
1 080 5A3C 0
3 0805 0 080
5 3 0 0
5 5 0 0
3 0B80 3 0B8
3 1C43 0 1C4
2 2 0 0
3 1C43 0 1C3
3 1FC0 0 1F8
5 2 0 0
5 7 0 0
5 6 0 0
2 1 0 0
3 0AC0 0 0AC
5 4 0 0
3 0AC7 0 0AC
5 4 0 0
3 0805 0 080
5 2 0 0
1 0A0 0400 0
3 0A00 0 0A0
4 000000000 0 0
4 800000000 1 1
1 0A1 0200 0
3 0A10 0 0A1
4 400000000 4 2
4 200000000 2 2
4 FFFFFFFFF 2 1
4 100000000 3 2
4 080000000 6 2
4 040000000 0 2
4 020000000 4 2
4 010000000 0 3
4 008000000 5 4
4 004000000 0 5
4 002000000 0 6
4 001000000 0 7
4 000008000 0 7
1 0A2 0C00 0
3 0A20 0 0A2
4 123456789 0 2
4 00F000000 1 4
4 000000000 1 0
5 0 0 0
5 1 0 0
5 2 0 0
5 3 0 0
5 4 0 0
5 5 0 0
5 6 0 0
5 7 0 0
0 0 0 0
